// File: hdl/freq_counter_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frequency counter widths, register map,
// axi response codes and seven-segment patterns
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package freq_counter_pkg;

	// edge count and binary result
	localparam int count_width = 24;

	// packed bcd, four bits per digit
	localparam int bcd_digits = 8;
	localparam int bcd_width = bcd_digits * 4;

	// gate length in system clock cycles
	localparam int gate_width = 32;

	// axi4-lite bus widths
	localparam int addr_width = 5;
	localparam int data_width = 32;
	localparam int strb_width = data_width / 8;

	// register byte offsets
	localparam logic [addr_width-1:0] addr_control = 5'h00;
	localparam logic [addr_width-1:0] addr_gate = 5'h04;
	localparam logic [addr_width-1:0] addr_status = 5'h08;
	localparam logic [addr_width-1:0] addr_result = 5'h0c;
	localparam logic [addr_width-1:0] addr_bcd = 5'h10;

	// bresp and rresp codes
	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// segments g down to a, a lit segment is 1
	localparam logic [6:0] segment_table [16] = '{
		7'b0111111, 7'b0000110, 7'b1011011, 7'b1001111,
		7'b1100110, 7'b1101101, 7'b1111101, 7'b0000111,
		7'b1111111, 7'b1101111, 7'b1110111, 7'b1111100,
		7'b0111001, 7'b1011110, 7'b1111001, 7'b1110001
	};

endpackage

// File: hdl/gate_timer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// gate timer, repeating measurement
// window and gate-end pulse
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module gate_timer import freq_counter_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  enable,
	input  logic [gate_width-1:0] gate_cycles,
	output logic                  gate_open,
	output logic                  gate_end
);

	// window flop and cycles left in it
	logic                  window;
	logic [gate_width-1:0] remaining;
	logic                  last_cycle;

	// one cycle left means this is the final cycle of the window
	assign last_cycle = (remaining == gate_width'(1));

	// dropping enable shuts the window in the same cycle
	assign gate_open = window & enable;

	// no gate_end once enable is gone
	assign gate_end = gate_open & last_cycle;

	always_ff @(posedge clock) begin
		if (reset || !enable) begin
			window <= 1'b0;
			remaining <= '0;
		end else if (!window || last_cycle) begin
			// start of a window, or back-to-back restart
			window <= 1'b1;
			// length sampled only here
			remaining <= gate_cycles;
		end else begin
			remaining <= remaining - 1'b1;
		end
	end

endmodule

// File: hdl/edge_accumulator.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// input synchronizer, rising edge
// counter and end-of-gate latch
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module edge_accumulator import freq_counter_pkg::*; (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   signal_in,
	input  logic                   gate_open,
	input  logic                   gate_end,
	output logic [count_width-1:0] count,
	output logic                   count_valid
);

	// two synchronizer stages, then the edge register
	logic sync_1;
	logic sync_2;
	logic sync_3;
	logic rising;

	// running count for the open window
	logic [count_width-1:0] counter;
	logic [count_width-1:0] counted;

	assign rising = sync_2 & ~sync_3;

	// stick at all ones when full
	assign counted = (rising && counter != '1) ? counter + 1'b1 : counter;

	always_ff @(posedge clock) begin
		if (reset) begin
			sync_1 <= 1'b0;
			sync_2 <= 1'b0;
			sync_3 <= 1'b0;
			counter <= '0;
			count_valid <= 1'b0;
		end else begin
			sync_1 <= signal_in;
			sync_2 <= sync_1;
			sync_3 <= sync_2;
			// result strobe trails gate_end by one cycle
			count_valid <= gate_end;
			// closed window, or last cycle of one, starts from zero
			if (!gate_open || gate_end) begin
				counter <= '0;
			end else begin
				counter <= counted;
			end
		end
	end

	// total includes an edge landing on the last window cycle
	always_ff @(posedge clock) begin
		if (gate_end) begin
			count <= counted;
		end
	end

endmodule

// File: hdl/hex_to_bcd.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// iterative binary to packed bcd
// converter, double dabble
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module hex_to_bcd import freq_counter_pkg::*; (
	input  logic                   clock,
	input  logic                   reset,
	input  logic [count_width-1:0] count,
	input  logic                   count_valid,
	output logic [bcd_width-1:0]   bcd,
	output logic                   bcd_valid
);

	localparam int bit_count_width = $clog2(count_width + 1);

	// conversion state
	logic                       busy;
	logic [bit_count_width-1:0] bits_left;

	// working registers
	logic [count_width-1:0] binary;
	logic [bcd_width-1:0]   bcd_work;
	logic [bcd_width-1:0]   adjusted;
	logic [bcd_width-1:0]   shifted;

	// add 3 to any digit of 5 or more before the shift
	always_comb begin
		adjusted = bcd_work;
		for (int i = 0; i < bcd_digits; i++) begin
			if (bcd_work[4*i +: 4] >= 4'd5) begin
				adjusted[4*i +: 4] = bcd_work[4*i +: 4] + 4'd3;
			end
		end
	end

	// msb of the binary word enters at the bottom
	assign shifted = {adjusted[bcd_width-2:0], binary[count_width-1]};

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			bits_left <= '0;
			bcd_valid <= 1'b0;
		end else begin
			bcd_valid <= 1'b0;
			if (!busy) begin
				// a start while busy is simply not seen
				if (count_valid) begin
					busy <= 1'b1;
					bits_left <= bit_count_width'(count_width);
				end
			end else begin
				bits_left <= bits_left - 1'b1;
				if (bits_left == bit_count_width'(1)) begin
					busy <= 1'b0;
					bcd_valid <= 1'b1;
				end
			end
		end
	end

	// datapath, one bit per busy cycle
	always_ff @(posedge clock) begin
		if (!busy && count_valid) begin
			binary <= count;
			bcd_work <= '0;
		end else if (busy) begin
			binary <= binary << 1;
			bcd_work <= shifted;
			// final shift goes straight to the output
			if (bits_left == bit_count_width'(1)) begin
				bcd <= shifted;
			end
		end
	end

endmodule

// File: hdl/segment_display_driver.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// eight digit multiplexed
// seven-segment driver
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module segment_display_driver import freq_counter_pkg::*; #(
	parameter int digit_dwell = 125_000,
	parameter int decimal_point = 6
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic [bcd_width-1:0]  bcd,
	input  logic                  bcd_valid,
	output logic [6:0]            segment,
	output logic                  decimal_point_out,
	output logic [bcd_digits-1:0] anode
);

	localparam int dwell_width = $clog2(digit_dwell + 1);
	localparam int index_width = $clog2(bcd_digits);

	// word on display, blank is all zeros
	logic [bcd_width-1:0] shown;

	// scan state
	logic [dwell_width-1:0] dwell;
	logic [index_width-1:0] digit_index;
	logic                   dwell_done;
	logic [3:0]             digit;

	assign dwell_done = (dwell == dwell_width'(digit_dwell - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			shown <= '0;
			dwell <= '0;
			digit_index <= '0;
			// digit 0 lit first
			anode <= bcd_digits'(1);
		end else begin
			// new value picked up straight away, mid-scan
			if (bcd_valid) begin
				shown <= bcd;
			end
			if (dwell_done) begin
				dwell <= '0;
				// index wraps from 7 back to 0 by itself
				digit_index <= digit_index + 1'b1;
				anode <= {anode[bcd_digits-2:0], anode[bcd_digits-1]};
			end else begin
				dwell <= dwell + 1'b1;
			end
		end
	end

	// nybble for the lit digit
	assign digit = shown[4*digit_index +: 4];

	// pattern lookup
	assign segment = segment_table[digit];

	// point follows the anode of its digit
	assign decimal_point_out = anode[decimal_point];

endmodule

// File: hdl/axi_lite_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// axi4-lite register slave, control,
// gate length, status and results
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module axi_lite_regs import freq_counter_pkg::*; #(
	parameter int default_gate = 125_000_000
) (
	input  logic                   clock,
	input  logic                   reset,
	input  logic [addr_width-1:0]  awaddr,
	input  logic                   awvalid,
	output logic                   awready,
	input  logic [data_width-1:0]  wdata,
	input  logic [strb_width-1:0]  wstrb,
	input  logic                   wvalid,
	output logic                   wready,
	output logic [1:0]             bresp,
	output logic                   bvalid,
	input  logic                   bready,
	input  logic [addr_width-1:0]  araddr,
	input  logic                   arvalid,
	output logic                   arready,
	output logic [data_width-1:0]  rdata,
	output logic [1:0]             rresp,
	output logic                   rvalid,
	input  logic                   rready,
	input  logic [count_width-1:0] count,
	input  logic                   count_valid,
	input  logic [bcd_width-1:0]   bcd,
	input  logic                   bcd_valid,
	output logic                   enable,
	output logic [gate_width-1:0]  gate_cycles
);

	// result path
	logic [count_width-1:0] pending_count;
	logic [count_width-1:0] result;
	logic [bcd_width-1:0]   bcd_result;
	logic                   new_result;

	// decode
	logic [gate_width-1:0] gate_merged;
	logic [gate_width-1:0] gate_limited;
	logic [data_width-1:0] read_word;
	logic [1:0]            read_resp;
	logic [1:0]            write_resp;

	// byte lanes of the gate register
	always_comb begin
		for (int i = 0; i < strb_width; i++) begin
			gate_merged[8*i +: 8] = wstrb[i] ? wdata[8*i +: 8] : gate_cycles[8*i +: 8];
		end
	end

	// floor of 2 cycles
	assign gate_limited = (gate_merged < gate_width'(2)) ? gate_width'(2) : gate_merged;

	// read-only registers still answer okay on write
	always_comb begin
		case (awaddr)
			addr_control, addr_gate, addr_status, addr_result, addr_bcd: write_resp = resp_okay;
			default: write_resp = resp_slverr;
		endcase
	end

	always_comb begin
		read_word = '0;
		read_resp = resp_okay;
		case (araddr)
			addr_control: read_word = data_width'(enable);
			addr_gate: read_word = data_width'(gate_cycles);
			addr_status: read_word = data_width'(new_result);
			addr_result: read_word = data_width'(result);
			addr_bcd: read_word = data_width'(bcd_result);
			default: read_resp = resp_slverr;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			arready <= 1'b0;
			rvalid <= 1'b0;
			enable <= 1'b0;
			gate_cycles <= gate_width'(default_gate);
			result <= '0;
			bcd_result <= '0;
			new_result <= 1'b0;
		end else begin
			// address and data together, and nothing held in b
			awready <= awvalid && wvalid && !awready && !bvalid;
			wready <= awvalid && wvalid && !awready && !bvalid;
			arready <= arvalid && !arready && !rvalid;
			// awready high is the handshake cycle
			if (awready) begin
				bvalid <= 1'b1;
				if (awaddr == addr_control && wstrb[0]) begin
					enable <= wdata[0];
				end
				if (awaddr == addr_gate) begin
					gate_cycles <= gate_limited;
				end
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
			if (arready) begin
				rvalid <= 1'b1;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
			// publish the pair, a fresh result beats a clearing read
			if (bcd_valid) begin
				result <= pending_count;
				bcd_result <= bcd;
				new_result <= 1'b1;
			end else if (arready && araddr == addr_result) begin
				new_result <= 1'b0;
			end
		end
	end

	// response payloads, held steady while valid waits
	always_ff @(posedge clock) begin
		if (awready) begin
			bresp <= write_resp;
		end
		if (arready) begin
			rdata <= read_word;
			rresp <= read_resp;
		end
		// binary count waits here for its bcd twin
		if (count_valid) begin
			pending_count <= count;
		end
	end

endmodule

// File: hdl/freq_counter_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frequency counter top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module freq_counter_top import freq_counter_pkg::*; #(
	// one second at 125 MHz, so the count reads in hertz
	parameter int default_gate = 125_000_000,
	// 1 ms per digit
	parameter int digit_dwell = 125_000,
	parameter int decimal_point = 6
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  signal_in,
	input  logic [addr_width-1:0] awaddr,
	input  logic                  awvalid,
	output logic                  awready,
	input  logic [data_width-1:0] wdata,
	input  logic [strb_width-1:0] wstrb,
	input  logic                  wvalid,
	output logic                  wready,
	output logic [1:0]            bresp,
	output logic                  bvalid,
	input  logic                  bready,
	input  logic [addr_width-1:0] araddr,
	input  logic                  arvalid,
	output logic                  arready,
	output logic [data_width-1:0] rdata,
	output logic [1:0]            rresp,
	output logic                  rvalid,
	input  logic                  rready,
	output logic [6:0]            segment,
	output logic                  decimal_point_out,
	output logic [bcd_digits-1:0] anode
);

	// control from the register block
	logic                  enable;
	logic [gate_width-1:0] gate_cycles;

	// gate window
	logic gate_open;
	logic gate_end;

	// results
	logic [count_width-1:0] count;
	logic                   count_valid;
	logic [bcd_width-1:0]   bcd;
	logic                   bcd_valid;

	gate_timer i_gate_timer (
		.clock(clock), .reset(reset), .enable(enable), .gate_cycles(gate_cycles),
		.gate_open(gate_open), .gate_end(gate_end)
	);

	edge_accumulator i_edge_accumulator (
		.clock(clock), .reset(reset), .signal_in(signal_in), .gate_open(gate_open),
		.gate_end(gate_end), .count(count), .count_valid(count_valid)
	);

	hex_to_bcd i_hex_to_bcd (
		.clock(clock), .reset(reset), .count(count), .count_valid(count_valid),
		.bcd(bcd), .bcd_valid(bcd_valid)
	);

	segment_display_driver #(
		.digit_dwell(digit_dwell), .decimal_point(decimal_point)
	) i_segment_display_driver (
		.clock(clock), .reset(reset), .bcd(bcd), .bcd_valid(bcd_valid),
		.segment(segment), .decimal_point_out(decimal_point_out), .anode(anode)
	);

	axi_lite_regs #(
		.default_gate(default_gate)
	) i_axi_lite_regs (
		.clock(clock), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.count(count), .count_valid(count_valid), .bcd(bcd), .bcd_valid(bcd_valid),
		.enable(enable), .gate_cycles(gate_cycles)
	);

endmodule

// File: testbench/tb_clock_gen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset source
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clock,
	output logic reset
);

	// 8 ns period
	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// high for 5 rising edges, dropped on an edge
	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

// File: testbench/tb_freq_counter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frequency counter testbench, axi
// register checks, counts and display scan
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_freq_counter import freq_counter_pkg::*;;

	// small values so a run stays short
	localparam int default_gate_value = 1000;
	localparam int digit_dwell_value = 4;
	localparam int decimal_point_value = 6;

	// wait limits
	localparam int handshake_limit = 50;
	localparam int poll_limit = 5000;
	localparam int reset_limit = 20;

	localparam logic [addr_width-1:0] addr_unmapped = 5'h14;

	logic                  clock;
	logic                  reset;
	logic                  signal_in = 1'b0;
	logic [addr_width-1:0] awaddr;
	logic                  awvalid;
	logic                  awready;
	logic [data_width-1:0] wdata;
	logic [strb_width-1:0] wstrb;
	logic                  wvalid;
	logic                  wready;
	logic [1:0]            bresp;
	logic                  bvalid;
	logic                  bready;
	logic [addr_width-1:0] araddr;
	logic                  arvalid;
	logic                  arready;
	logic [data_width-1:0] rdata;
	logic [1:0]            rresp;
	logic                  rvalid;
	logic                  rready;
	logic [6:0]            segment;
	logic                  decimal_point_out;
	logic [bcd_digits-1:0] anode;

	// toggler state, half period in clock cycles
	int   half_period = 4;
	int   start_offset = 0;
	int   phase = 0;
	logic reload = 1'b0;

	tb_clock_gen i_clock_gen (.clock(clock), .reset(reset));

	freq_counter_top #(
		.default_gate(default_gate_value),
		.digit_dwell(digit_dwell_value),
		.decimal_point(decimal_point_value)
	) i_freq_counter_top (.*);

	// square wave, phase restarted from a random offset on reload
	always @(posedge clock) begin
		if (reset || reload) begin
			phase <= start_offset;
		end else if (phase <= 0) begin
			signal_in <= ~signal_in;
			phase <= half_period - 1;
		end else begin
			phase <= phase - 1;
		end
	end

	task automatic stop_with(input string reason);
		$display("%s", reason);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_result(input string name, input logic [count_width-1:0] expected,
		input logic [count_width-1:0] actual, input int tolerance);
		int difference;
		difference = int'(actual) - int'(expected);
		if (difference > tolerance || difference < -tolerance) begin
			stop_with($sformatf("Error: %s expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic check_data(input string name, input logic [data_width-1:0] expected,
		input logic [data_width-1:0] actual);
		if (actual !== expected) begin
			stop_with($sformatf("Error: %s expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic check_bcd(input string name, input logic [bcd_width-1:0] expected,
		input logic [bcd_width-1:0] actual);
		if (actual !== expected) begin
			stop_with($sformatf("Error: %s expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] expected,
		input logic [1:0] actual);
		if (actual !== expected) begin
			stop_with($sformatf("Error: %s expected %h actual %h", name, expected, actual));
		end
	endtask

	// digit value is {point, segments}
	task automatic check_digit(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected) begin
			stop_with($sformatf("Error: %s expected %h actual %h", name, expected, actual));
		end
	endtask

	// decimal digits by repeated division, lowest digit first
	function automatic logic [bcd_width-1:0] decimal_digits(input logic [count_width-1:0] value);
		logic [bcd_width-1:0] digits;
		int rest;
		digits = '0;
		rest = int'(value);
		for (int i = 0; i < bcd_digits; i++) begin
			digits[4*i +: 4] = 4'(rest % 10);
			rest = rest / 10;
		end
		return digits;
	endfunction

	task automatic write_reg(input logic [addr_width-1:0] addr,
		input logic [data_width-1:0] data, output logic [1:0] resp);
		int cycles;
		cycles = 0;
		@(posedge clock);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wstrb <= '1;
		wvalid <= 1'b1;
		bready <= 1'b1;
		@(negedge clock);
		while (!awready) begin
			if (cycles == handshake_limit) stop_with("write address never accepted");
			cycles++;
			@(negedge clock);
		end
		// data channel taken in the same cycle as the address
		if (!wready) stop_with("wready did not rise together with awready");
		@(posedge clock);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		cycles = 0;
		@(negedge clock);
		while (!bvalid) begin
			if (cycles == handshake_limit) stop_with("write response never arrived");
			cycles++;
			@(negedge clock);
		end
		resp = bresp;
		// bvalid drops on this edge, bready still high
		@(posedge clock);
		bready <= 1'b0;
	endtask

	// hold is the number of cycles rready stays low with rvalid up
	task automatic read_reg(input logic [addr_width-1:0] addr, input int hold,
		output logic [data_width-1:0] data, output logic [1:0] resp);
		int cycles;
		cycles = 0;
		@(posedge clock);
		araddr <= addr;
		arvalid <= 1'b1;
		rready <= 1'b0;
		@(negedge clock);
		while (!arready) begin
			if (cycles == handshake_limit) stop_with("read address never accepted");
			cycles++;
			@(negedge clock);
		end
		@(posedge clock);
		if (hold > 0) begin
			// a second request has to wait behind the held response
			araddr <= addr_unmapped;
		end else begin
			arvalid <= 1'b0;
		end
		cycles = 0;
		@(negedge clock);
		while (!rvalid) begin
			if (cycles == handshake_limit) stop_with("read data never arrived");
			cycles++;
			@(negedge clock);
		end
		data = rdata;
		resp = rresp;
		// back-pressure, payload must not move
		repeat (hold) begin
			@(negedge clock);
			if (!rvalid) stop_with("rvalid dropped while rready was low");
			if (arready) stop_with("read address accepted while a response was held");
			check_data("rdata", data, rdata);
			check_resp("rresp", resp, rresp);
		end
		@(posedge clock);
		rready <= 1'b1;
		arvalid <= 1'b0;
		@(posedge clock);
		rready <= 1'b0;
	endtask

	task automatic write_register(input logic [addr_width-1:0] addr,
		input logic [data_width-1:0] data);
		logic [1:0] resp;
		write_reg(addr, data, resp);
		check_resp("bresp", resp_okay, resp);
	endtask

	task automatic expect_register(input logic [addr_width-1:0] addr, input string name,
		input logic [data_width-1:0] expected);
		logic [data_width-1:0] data;
		logic [1:0] resp;
		read_reg(addr, 0, data, resp);
		check_resp("rresp", resp_okay, resp);
		check_data(name, expected, data);
	endtask

	task automatic wait_new_result();
		logic [data_width-1:0] data;
		logic [1:0] resp;
		int polls;
		polls = 0;
		data = '0;
		while (!data[0]) begin
			if (polls == poll_limit) stop_with("new_result never set while polling status");
			read_reg(addr_status, 0, data, resp);
			check_resp("rresp", resp_okay, resp);
			polls++;
		end
	endtask

	// one full scan, every lit digit against the table
	task automatic check_display_scan(input logic [bcd_width-1:0] bcd_word);
		logic [bcd_digits-1:0] seen;
		logic [7:0] expected;
		int index;
		seen = '0;
		repeat (bcd_digits * digit_dwell_value) begin
			@(negedge clock);
			if ($countones(anode) != 1) stop_with("anode is not one-hot");
			index = 0;
			for (int i = 0; i < bcd_digits; i++) begin
				if (anode[i]) index = i;
			end
			expected = {index == decimal_point_value, segment_table[bcd_word[4*index +: 4]]};
			check_digit($sformatf("digit %0d", index), expected, {decimal_point_out, segment});
			seen[index] = 1'b1;
		end
		if (seen != '1) stop_with("display scan skipped a digit");
	endtask

	task automatic run_case(input int gate_length, input int half, input int expected);
		logic [data_width-1:0] data;
		logic [1:0] resp;
		logic [count_width-1:0] result;
		@(posedge clock);
		half_period <= half;
		start_offset <= int'($urandom % (2 * half));
		reload <= 1'b1;
		@(posedge clock);
		reload <= 1'b0;
		// stop, clear a leftover flag, then restart with the new gate
		write_register(addr_control, '0);
		read_reg(addr_result, 0, data, resp);
		write_register(addr_gate, data_width'(gate_length));
		write_register(addr_control, data_width'(1));
		// first result may predate the new gate
		wait_new_result();
		read_reg(addr_result, 0, data, resp);
		wait_new_result();
		read_reg(addr_result, 0, data, resp);
		check_resp("rresp", resp_okay, resp);
		result = data[count_width-1:0];
		check_result("result", count_width'(expected), result, 1);
		// result read clears the flag
		expect_register(addr_status, "status", '0);
		read_reg(addr_bcd, 0, data, resp);
		check_resp("rresp", resp_okay, resp);
		check_bcd("bcd", decimal_digits(result), data);
		check_display_scan(data);
	endtask

	initial begin
		int fd;
		int fields;
		int gate_length;
		int half;
		int expected;
		int cases;
		int cycles;
		string line;
		logic [data_width-1:0] data;
		logic [1:0] resp;
		void'($urandom(32'hf723_ae04));
		awaddr <= '0;
		awvalid <= 1'b0;
		wdata <= '0;
		wstrb <= '0;
		wvalid <= 1'b0;
		bready <= 1'b0;
		araddr <= '0;
		arvalid <= 1'b0;
		rready <= 1'b0;
		cycles = 0;
		@(posedge clock);
		while (reset) begin
			if (cycles == reset_limit) stop_with("reset was never released");
			cycles++;
			@(posedge clock);
		end
		// state after reset
		expect_register(addr_control, "control", '0);
		expect_register(addr_gate, "gate", data_width'(default_gate_value));
		expect_register(addr_status, "status", '0);
		expect_register(addr_result, "result", '0);
		expect_register(addr_bcd, "bcd", '0);
		check_display_scan('0);
		// unmapped address both ways
		read_reg(addr_unmapped, 0, data, resp);
		check_resp("rresp", resp_slverr, resp);
		check_data("rdata", '0, data);
		write_reg(addr_unmapped, 32'hffff_ffff, resp);
		check_resp("bresp", resp_slverr, resp);
		// gate floor, read back under back-pressure
		write_register(addr_gate, '0);
		read_reg(addr_gate, 6, data, resp);
		check_resp("rresp", resp_okay, resp);
		check_data("gate", data_width'(2), data);
		// read-only result
		write_register(addr_result, 32'h0012_3456);
		expect_register(addr_result, "result", '0);
		fd = $fopen("testbench/freq_counter_stimulus.txt", "r");
		if (fd == 0) stop_with("could not open the stimulus file");
		cases = 0;
		while (!$feof(fd)) begin
			line = "";
			fields = $fgets(line, fd);
			if (fields != 0 && line.len() > 1 && line.getc(0) != "#") begin
				fields = $sscanf(line, "%d %d %d", gate_length, half, expected);
				if (fields == 3) begin
					run_case(gate_length, half, expected);
					cases++;
				end
			end
		end
		$fclose(fd);
		if (cases == 0) begin
			stop_with("no cases found in the stimulus file");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

// File: testbench/freq_counter_stimulus.txt
# gate_cycles half_period_cycles expected_count (decimal)
# expected_count is the whole number of signal periods in one gate
1000 4 125
2000 5 200
1500 7 107
4096 3 682
3000 25 60
800 2 200
10000 1 5000
12345 9 685

// File: all.f
hdl/freq_counter_pkg.sv
hdl/gate_timer.sv
hdl/edge_accumulator.sv
hdl/hex_to_bcd.sv
hdl/segment_display_driver.sv
hdl/axi_lite_regs.sv
hdl/freq_counter_top.sv
testbench/tb_clock_gen.sv
testbench/tb_freq_counter.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the frequency counter testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_freq_counter -f all.f
output=$(./obj_dir/Vtb_freq_counter || true)
echo "$output"
if echo "$output" | grep -q "^TEST PASS$"; then
	exit 0
else
	exit 1
fi
